//--- src/cop0_consts.svh
`ifndef COP0_CONSTS_SVH
`define COP0_CONSTS_SVH

// Register addresses as {rd, sel}
`define CP0_INDEX       8'h00
`define CP0_ENTRYLO0    8'h10
`define CP0_ENTRYLO1    8'h18
`define CP0_CONTEXT     8'h20
`define CP0_BADVADDR    8'h40
`define CP0_COUNT       8'h48
`define CP0_ENTRYHI     8'h50
`define CP0_COMPARE     8'h58
`define CP0_STATUS      8'h60
`define CP0_CAUSE       8'h68
`define CP0_EPC         8'h70
`define CP0_PRID        8'h78
`define CP0_EBASE       8'h79
`define CP0_CONFIG      8'h80
`define CP0_CONFIG1     8'h81

`define OP_COP0         6'h10
`define RS_MF           5'd0
`define RS_MT           5'd4

`define FN_TLBR         6'd1
`define FN_TLBWI        6'd2
`define FN_TLBP         6'd8
`define FN_ERET         6'd24

`define STATUS_RESET    32'h1040_0004
`define EBASE_RESET     32'h8000_0000
`define PRID_RESET      32'h0001_8000 // 4Kc
`define CONFIG_RESET    32'h8000_0080 // MIPS32R1, kseg0 cacheable
`define CONFIG1_RESET   32'h1E68_3400

`define EXC_OFFSET      32'h180
`define TLB_ENTRIES     16

`endif

//--- src/cop0Pkg.sv
package cop0Pkg;

    // MFC0 / MTC0 layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [7:0] zero;
        logic [2:0] sel;
    } cop0Move;

    // TLBR, TLBWI, TLBP, ERET layout
    typedef struct packed {
        logic [5:0]  opcode;
        logic        co;
        logic [18:0] zero;
        logic [5:0]  funct;
    } cop0Op;

    typedef union packed {
        cop0Move move;
        cop0Op   cop;
    } cop0Instr;

    typedef logic [7:0] cop0Addr; // {rd, sel}

    // Same bit layout as the configuration vector of the TLB
    typedef struct packed {
        logic [18:0] vpn2;
        logic        isGlobal;
        logic [7:0]  asid;
        logic [28:0] lo0;  // PFN, C, D, V
        logic [28:0] lo1;
    } tlbEntry;

endpackage

//--- src/cop0Decode.sv
`timescale 1ns/1ps
`include "cop0_consts.svh"

module cop0Decode
    import cop0Pkg::*;
(
    input  cop0Instr instr,
    input  logic     instrValid,
    input  logic     excReq,
    output logic     doMove,
    output logic     doWrite,
    output logic     doTlbr,
    output logic     doTlbwi,
    output logic     doTlbp,
    output logic     doEret,
    output cop0Addr  regAddr
);

    logic active;

    // Exception wins over any instruction in the same cycle
    assign active  = instrValid && !excReq && (instr.move.opcode == `OP_COP0);
    assign regAddr = {instr.move.rd, instr.move.sel};

    always_comb begin
        doMove  = 1'b0;
        doWrite = 1'b0;
        doTlbr  = 1'b0;
        doTlbwi = 1'b0;
        doTlbp  = 1'b0;
        doEret  = 1'b0;
        if (active) begin
            if (instr.cop.co) begin
                if (instr.cop.zero == '0) begin
                    case (instr.cop.funct)
                        `FN_TLBR:  doTlbr  = 1'b1;
                        `FN_TLBWI: doTlbwi = 1'b1;
                        `FN_TLBP:  doTlbp  = 1'b1;
                        `FN_ERET:  doEret  = 1'b1;
                        default: begin
                            // TLBWR, WAIT and the rest are ignored
                        end
                    endcase
                end
            end else begin
                case (instr.move.rs)
                    `RS_MF:  doMove  = 1'b1;
                    `RS_MT:  doWrite = 1'b1;
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- src/cop0Regs.sv
`timescale 1ns/1ps
`include "cop0_consts.svh"

module cop0Regs
    import cop0Pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [5:0]  hint,
    input  cop0Addr     regAddr,
    input  logic        doWrite,
    input  logic [31:0] wdata,
    input  logic        doTlbr,
    input  logic        doTlbp,
    input  logic        exlSet,
    input  logic        exlClear,
    input  logic [4:0]  excCode,
    input  logic        excBd,
    input  logic [31:0] excPc,
    input  logic [31:0] excBadVaddr,
    input  logic        excBadVaddrValid,
    input  tlbEntry     readEntry,
    input  logic        probeHit,
    input  logic [3:0]  probeIndex,
    output logic [31:0] rdata,
    output logic [31:0] epc,
    output logic [31:0] ebase,
    output logic [3:0]  tlbIndex,
    output tlbEntry     entryOut,
    output logic        allowInterrupt,
    output logic [7:0]  interruptFlag,
    output logic        kseg0Uncached,
    output logic [7:0]  asid
);

    logic [31:0] index, entryLo0, entryLo1, contextReg, badVaddr, entryHi;
    logic [31:0] compare, status, cause, epcReg, prid, ebaseReg, config0, config1;
    logic [32:0] count; // Runs at twice the read rate

    assign epc            = epcReg;
    assign ebase          = ebaseReg;
    assign tlbIndex       = index[3:0];
    assign asid           = entryHi[7:0];
    assign allowInterrupt = status[2:0] == 3'b001; // IE set, EXL and ERL clear
    assign interruptFlag  = status[15:8] & cause[15:8];
    assign kseg0Uncached  = config0[2:0] == 3'd2;

    // Global only when both halves are global
    assign entryOut = {entryHi[31:13], entryLo0[0] & entryLo1[0], entryHi[7:0],
                       entryLo0[29:1], entryLo1[29:1]};

    always_comb begin
        case (regAddr)
            `CP0_INDEX:    rdata = index;
            `CP0_ENTRYLO0: rdata = entryLo0;
            `CP0_ENTRYLO1: rdata = entryLo1;
            `CP0_CONTEXT:  rdata = contextReg;
            `CP0_BADVADDR: rdata = badVaddr;
            `CP0_COUNT:    rdata = count[32:1];
            `CP0_ENTRYHI:  rdata = entryHi;
            `CP0_COMPARE:  rdata = compare;
            `CP0_STATUS:   rdata = status;
            `CP0_CAUSE:    rdata = cause;
            `CP0_EPC:      rdata = epcReg;
            `CP0_PRID:     rdata = prid;
            `CP0_EBASE:    rdata = ebaseReg;
            `CP0_CONFIG:   rdata = config0;
            `CP0_CONFIG1:  rdata = config1;
            default:       rdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index      <= 32'd0;
            entryLo0   <= 32'd0;
            entryLo1   <= 32'd0;
            contextReg <= 32'd0;
            count      <= 33'd0;
            entryHi    <= 32'd0;
            compare    <= 32'd0;
            status     <= `STATUS_RESET;
            cause      <= 32'd0;
            prid       <= `PRID_RESET;
            ebaseReg   <= `EBASE_RESET;
            config0    <= `CONFIG_RESET;
            config1    <= `CONFIG1_RESET;
        end else begin
            cause[15:10] <= hint;
            count        <= count + 33'd1;
            if (doWrite) begin
                case (regAddr)
                    `CP0_INDEX:    index[3:0]        <= wdata[3:0];
                    `CP0_ENTRYLO0: entryLo0[29:0]    <= wdata[29:0];
                    `CP0_ENTRYLO1: entryLo1[29:0]    <= wdata[29:0];
                    `CP0_CONTEXT:  contextReg[31:13] <= wdata[31:13];
                    `CP0_COUNT:    count             <= {wdata, 1'b0};
                    `CP0_ENTRYHI: begin
                        entryHi[31:13] <= wdata[31:13];
                        entryHi[7:0]   <= wdata[7:0];
                    end
                    `CP0_COMPARE:  compare           <= wdata;
                    `CP0_STATUS: begin
                        status[28]   <= wdata[28]; // CU0
                        status[22]   <= wdata[22]; // BEV
                        status[15:8] <= wdata[15:8];
                        status[4]    <= wdata[4];
                        status[2:0]  <= wdata[2:0];
                    end
                    `CP0_CAUSE: begin
                        cause[23]  <= wdata[23];   // IV
                        cause[9:8] <= wdata[9:8];  // Software interrupts
                    end
                    `CP0_EPC:      epcReg            <= wdata;
                    `CP0_EBASE:    ebaseReg[29:12]   <= wdata[29:12];
                    `CP0_CONFIG:   config0[2:0]      <= wdata[2:0];
                    default: begin
                    end
                endcase
            end
            if (exlSet) begin
                epcReg     <= excPc;
                cause[31]  <= excBd;
                cause[6:2] <= excCode;
                status[1]  <= 1'b1;
                if (excBadVaddrValid) begin
                    badVaddr         <= excBadVaddr;
                    contextReg[22:4] <= excBadVaddr[31:13]; // BadVPN2
                    entryHi[31:13]   <= excBadVaddr[31:13];
                end
            end
            if (exlClear)
                status[1] <= 1'b0;
            if (doTlbr) begin
                entryHi[31:13] <= readEntry.vpn2;
                entryHi[7:0]   <= readEntry.asid;
                entryLo0       <= {2'b00, readEntry.lo0, readEntry.isGlobal};
                entryLo1       <= {2'b00, readEntry.lo1, readEntry.isGlobal};
            end
            if (doTlbp) begin
                index[31]  <= ~probeHit;
                index[3:0] <= probeIndex;
            end
        end
    end

endmodule

//--- src/tlbArray.sv
`timescale 1ns/1ps
`include "cop0_consts.svh"

module tlbArray
    import cop0Pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        doTlbwi,
    input  logic [3:0]  tlbIndex,
    input  tlbEntry     entryIn,
    input  logic [18:0] probeVpn2,
    input  logic [7:0]  probeAsid,
    output tlbEntry     readEntry,
    output logic        probeHit,
    output logic [3:0]  probeIndex
);

    tlbEntry entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] match;

    assign readEntry = entries[tlbIndex];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TLB_ENTRIES; i++)
                entries[i] <= '0;
        end else if (doTlbwi) begin
            entries[tlbIndex] <= entryIn;
        end
    end

    // ASID is ignored for global pages
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = (entries[i].vpn2 == probeVpn2) &&
                       (entries[i].isGlobal || entries[i].asid == probeAsid);
        end
    end

    // Walk downwards so the lowest matching index is left
    always_comb begin
        probeHit   = 1'b0;
        probeIndex = 4'd0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                probeHit   = 1'b1;
                probeIndex = 4'(i);
            end
        end
    end

endmodule

//--- src/trapSequencer.sv
`timescale 1ns/1ps
`include "cop0_consts.svh"

module trapSequencer (
    input  logic        clk,
    input  logic        rst,
    input  logic        doMove,
    input  logic        doEret,
    input  logic        excReq,
    input  logic [31:0] rdata,
    input  logic [31:0] epc,
    input  logic [31:0] ebase,
    output logic [31:0] rtResult,
    output logic        rtWrite,
    output logic        redirect,
    output logic [31:0] redirectPc,
    output logic        exlSet,
    output logic        exlClear
);

    logic [31:0] target;

    assign exlSet   = excReq;
    assign exlClear = doEret;

    // Exception vector, otherwise return to EPC
    assign target = excReq ? ebase + `EXC_OFFSET : epc;

    always_ff @(posedge clk) begin
        if (rst) begin
            rtWrite  <= 1'b0;
            redirect <= 1'b0;
        end else begin
            rtWrite  <= doMove;
            redirect <= excReq | doEret;
        end
    end

    // Data only, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (doMove)
            rtResult <= rdata;
        if (excReq || doEret)
            redirectPc <= target;
    end

endmodule

//--- src/cop0Top.sv
`timescale 1ns/1ps

module cop0Top
    import cop0Pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cop0Instr    instr,
    input  logic        instrValid,
    input  logic [31:0] rtData,
    input  logic [5:0]  hint,
    input  logic        excReq,
    input  logic [4:0]  excCode,
    input  logic [31:0] excPc,
    input  logic        excBd,
    input  logic [31:0] excBadVaddr,
    input  logic        excBadVaddrValid,
    output logic [31:0] rtResult,
    output logic        rtWrite,
    output logic        redirect,
    output logic [31:0] redirectPc,
    output logic        allowInterrupt,
    output logic [7:0]  interruptFlag,
    output logic        kseg0Uncached,
    output logic [7:0]  asid
);

    logic        doMove, doWrite, doTlbr, doTlbwi, doTlbp, doEret;
    logic        exlSet, exlClear, probeHit;
    logic [3:0]  tlbIndex, probeIndex;
    logic [31:0] rdata, epc, ebase;
    cop0Addr     regAddr;
    tlbEntry     entryOut, readEntry;

    cop0Decode i_cop0Decode (
        .instr      (instr),
        .instrValid (instrValid),
        .excReq     (excReq),
        .doMove     (doMove),
        .doWrite    (doWrite),
        .doTlbr     (doTlbr),
        .doTlbwi    (doTlbwi),
        .doTlbp     (doTlbp),
        .doEret     (doEret),
        .regAddr    (regAddr)
    );

    cop0Regs i_cop0Regs (
        .clk              (clk),
        .rst              (rst),
        .hint             (hint),
        .regAddr          (regAddr),
        .doWrite          (doWrite),
        .wdata            (rtData),
        .doTlbr           (doTlbr),
        .doTlbp           (doTlbp),
        .exlSet           (exlSet),
        .exlClear         (exlClear),
        .excCode          (excCode),
        .excBd            (excBd),
        .excPc            (excPc),
        .excBadVaddr      (excBadVaddr),
        .excBadVaddrValid (excBadVaddrValid),
        .readEntry        (readEntry),
        .probeHit         (probeHit),
        .probeIndex       (probeIndex),
        .rdata            (rdata),
        .epc              (epc),
        .ebase            (ebase),
        .tlbIndex         (tlbIndex),
        .entryOut         (entryOut),
        .allowInterrupt   (allowInterrupt),
        .interruptFlag    (interruptFlag),
        .kseg0Uncached    (kseg0Uncached),
        .asid             (asid)
    );

    // Probe always looks up the current EntryHi
    tlbArray i_tlbArray (
        .clk        (clk),
        .rst        (rst),
        .doTlbwi    (doTlbwi),
        .tlbIndex   (tlbIndex),
        .entryIn    (entryOut),
        .probeVpn2  (entryOut.vpn2),
        .probeAsid  (entryOut.asid),
        .readEntry  (readEntry),
        .probeHit   (probeHit),
        .probeIndex (probeIndex)
    );

    trapSequencer i_trapSequencer (
        .clk        (clk),
        .rst        (rst),
        .doMove     (doMove),
        .doEret     (doEret),
        .excReq     (excReq),
        .rdata      (rdata),
        .epc        (epc),
        .ebase      (ebase),
        .rtResult   (rtResult),
        .rtWrite    (rtWrite),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .exlSet     (exlSet),
        .exlClear   (exlClear)
    );

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tests/cop0_assert.sv
`timescale 1ns/1ps

module cop0Assert
    import cop0Pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    excReq,
    input logic    doEret,
    input logic    doTlbwi,
    input logic    rtWrite,
    input logic    redirect,
    input tlbEntry entryOut,
    input tlbEntry readEntry
);

    int failCount = 0;

    noWriteWithRedirect: assert property (@(posedge clk) disable iff (rst)
        !(rtWrite && redirect))
    else begin
        $error("rtWrite and redirect high in the same cycle");
        failCount++;
    end

    redirectAfterTrap: assert property (@(posedge clk) disable iff (rst)
        (excReq || doEret) |=> redirect)
    else begin
        $error("redirect missing one cycle after exception or ERET");
        failCount++;
    end

    // No stray redirect
    redirectOnlyAfterTrap: assert property (@(posedge clk) disable iff (rst)
        redirect |-> $past(excReq || doEret))
    else begin
        $error("redirect without exception or ERET in the cycle before");
        failCount++;
    end

    quietInReset: assert property (@(posedge clk) rst |=> !rtWrite)
    else begin
        $error("rtWrite high after a reset cycle");
        failCount++;
    end

    entryWritten: assert property (@(posedge clk) disable iff (rst)
        doTlbwi |=> readEntry == $past(entryOut))
    else begin
        $error("TLB entry does not hold the written EntryHi/EntryLo");
        failCount++;
    end

endmodule

bind cop0Top cop0Assert i_cop0Assert (.*);

//--- tests/cop0Tb.sv
`timescale 1ns/1ps
`include "cop0_consts.svh"

module cop0Tb
    import cop0Pkg::*;
();

    typedef enum {expectNone, expectRead, expectMiss, expectRedirect,
                  expectEntry, expectAllow, expectFlags, expectAsid,
                  expectUncached} expectKind;

    typedef struct {
        string       name;
        cop0Instr    instr;
        logic        valid;
        logic [31:0] rtData;
        logic [5:0]  hint;
        logic        excReq;
        logic [4:0]  excCode;
        logic [31:0] excPc;
        logic        excBd;
        logic [31:0] badVaddr;
        logic        badValid;
        expectKind   kind;
        logic [31:0] expWord;
        tlbEntry     expEntry;
    } testRow;

    logic        clk, rst;
    cop0Instr    instr;
    logic        instrValid, excReq, excBd, excBadVaddrValid;
    logic [31:0] rtData, excPc, excBadVaddr, rtResult, redirectPc;
    logic [5:0]  hint;
    logic [4:0]  excCode;
    logic        rtWrite, redirect, allowInterrupt, kseg0Uncached;
    logic [7:0]  interruptFlag, asid;

    testRow      rows[$];
    logic [31:0] lfsr;
    int          cycles = 0;
    int          cycleLimit;

    clockGen i_clockGen (.clk(clk), .rst(rst));

    cop0Top i_cop0Top (.*);

    // Taps 32, 22, 2, 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] w;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], lfsrBit()};
        return w;
    endfunction

    function automatic logic [4:0] randomCode();
        logic [4:0] c;
        for (int i = 0; i < 5; i++)
            c = {c[3:0], lfsrBit()};
        return c;
    endfunction

    function automatic logic [31:0] maskedWrite(logic [31:0] old, logic [31:0] data,
                                                logic [31:0] mask);
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic cop0Instr moveInstr(logic [4:0] rs, cop0Addr addr);
        cop0Instr ins;
        ins.move.opcode = `OP_COP0;
        ins.move.rs     = rs;
        ins.move.rt     = 5'd8;
        ins.move.rd     = addr[7:3];
        ins.move.zero   = 8'd0;
        ins.move.sel    = addr[2:0];
        return ins;
    endfunction

    function automatic testRow idleRow(string name, expectKind kind);
        testRow r;
        r.name     = name;
        r.instr    = '0;
        r.valid    = 1'b0;
        r.rtData   = 32'd0;
        r.hint     = 6'd0;
        r.excReq   = 1'b0;
        r.excCode  = 5'd0;
        r.excPc    = 32'd0;
        r.excBd    = 1'b0;
        r.badVaddr = 32'd0;
        r.badValid = 1'b0;
        r.kind     = kind;
        r.expWord  = 32'd0;
        r.expEntry = '0;
        return r;
    endfunction

    function automatic testRow moveRow(string name, logic [4:0] rs, cop0Addr addr,
                                       logic [31:0] data, expectKind kind,
                                       logic [31:0] expWord);
        testRow r;
        r         = idleRow(name, kind);
        r.instr   = moveInstr(rs, addr);
        r.valid   = 1'b1;
        r.rtData  = data;
        r.expWord = expWord;
        return r;
    endfunction

    function automatic testRow opRow(string name, logic [5:0] funct, expectKind kind,
                                     logic [31:0] expWord, tlbEntry expEntry);
        testRow r;
        r                  = idleRow(name, kind);
        r.instr.cop.opcode = `OP_COP0;
        r.instr.cop.co     = 1'b1;
        r.instr.cop.zero   = 19'd0;
        r.instr.cop.funct  = funct;
        r.valid            = 1'b1;
        r.expWord          = expWord;
        r.expEntry         = expEntry;
        return r;
    endfunction

    // MFC0 rides along and must be dropped
    function automatic testRow excRow(string name, logic [4:0] code, logic [31:0] pc,
                                      logic bd, logic [31:0] bad, logic badValid,
                                      logic [31:0] target);
        testRow r;
        r          = moveRow(name, `RS_MF, `CP0_STATUS, 32'd0, expectRedirect, target);
        r.excReq   = 1'b1;
        r.excCode  = code;
        r.excPc    = pc;
        r.excBd    = bd;
        r.badVaddr = bad;
        r.badValid = badValid;
        return r;
    endfunction

    task automatic addMasked(string regName, cop0Addr addr, logic [31:0] old,
                             logic [31:0] mask, output logic [31:0] now);
        logic [31:0] data;
        data = randomWord();
        now  = maskedWrite(old, data, mask);
        rows.push_back(moveRow({regName, " write"}, `RS_MT, addr, data, expectNone, 0));
        rows.push_back(moveRow({regName, " read"}, `RS_MF, addr, 32'd0, expectRead, now));
    endtask

    task automatic buildTable();
        logic [31:0] data, causeExp, ebaseExp, hiA, lo0A, lo1A, missHi;
        logic [31:0] pc1, pc2, bad1, bad2;
        logic [4:0]  code1, code2;
        logic        glob;
        tlbEntry     entryA;
        testRow      r;
        rows.push_back(moveRow("status reset", `RS_MF, `CP0_STATUS, 0, expectRead,
                               `STATUS_RESET));
        rows.push_back(moveRow("ebase reset", `RS_MF, `CP0_EBASE, 0, expectRead,
                               `EBASE_RESET));
        rows.push_back(moveRow("prid reset", `RS_MF, `CP0_PRID, 0, expectRead,
                               32'h0001_8000));
        rows.push_back(moveRow("config reset", `RS_MF, `CP0_CONFIG, 0, expectRead,
                               32'h8000_0080)); // M set, MIPS32R1, TLB MMU
        rows.push_back(moveRow("unmapped", `RS_MF, 8'hF8, 0, expectRead, 32'd0));
        rows.push_back(idleRow("kseg0 cached", expectUncached));
        rows.push_back(moveRow("kseg0 uncached", `RS_MT, `CP0_CONFIG, 32'h0000_0002,
                               expectUncached, 32'd1));

        addMasked("status", `CP0_STATUS, `STATUS_RESET, 32'h1040_FF17, data);
        addMasked("cause", `CP0_CAUSE, 32'd0, 32'h0080_0300, causeExp);
        addMasked("entryhi", `CP0_ENTRYHI, 32'd0, 32'hFFFF_E0FF, data);
        addMasked("entrylo0", `CP0_ENTRYLO0, 32'd0, 32'h3FFF_FFFF, data);
        addMasked("entrylo1", `CP0_ENTRYLO1, 32'd0, 32'h3FFF_FFFF, data);
        addMasked("index", `CP0_INDEX, 32'd0, 32'h0000_000F, data);
        addMasked("ebase", `CP0_EBASE, `EBASE_RESET, 32'h3FFF_F000, ebaseExp);

        // Nonzero ASID keeps the cleared entries from matching
        hiA             = (randomWord() & 32'hFFFF_E0FF) | 32'h1;
        lo0A            = randomWord() & 32'h3FFF_FFFF;
        lo1A            = randomWord() & 32'h3FFF_FFFF;
        glob            = lo0A[0] & lo1A[0];
        missHi          = {~hiA[31:13], 5'd0, hiA[7:0]};
        entryA.vpn2     = hiA[31:13];
        entryA.isGlobal = glob;
        entryA.asid     = hiA[7:0];
        entryA.lo0      = lo0A[29:1];
        entryA.lo1      = lo1A[29:1];
        rows.push_back(moveRow("tlb hi", `RS_MT, `CP0_ENTRYHI, hiA, expectAsid,
                               {24'd0, hiA[7:0]}));
        rows.push_back(moveRow("tlb lo0", `RS_MT, `CP0_ENTRYLO0, lo0A, expectNone, 0));
        rows.push_back(moveRow("tlb lo1", `RS_MT, `CP0_ENTRYLO1, lo1A, expectNone, 0));
        rows.push_back(moveRow("tlb index", `RS_MT, `CP0_INDEX, 32'd5, expectNone, 0));
        rows.push_back(opRow("tlbwi", `FN_TLBWI, expectEntry, 0, entryA));
        rows.push_back(moveRow("hi change", `RS_MT, `CP0_ENTRYHI, missHi, expectNone, 0));
        rows.push_back(opRow("tlbr", `FN_TLBR, expectNone, 0, '0));
        rows.push_back(moveRow("tlbr hi", `RS_MF, `CP0_ENTRYHI, 0, expectRead, hiA));
        rows.push_back(moveRow("tlbr lo0", `RS_MF, `CP0_ENTRYLO0, 0, expectRead,
                               {2'b00, lo0A[29:1], glob}));
        rows.push_back(moveRow("tlbr lo1", `RS_MF, `CP0_ENTRYLO1, 0, expectRead,
                               {2'b00, lo1A[29:1], glob}));
        rows.push_back(opRow("tlbp hit", `FN_TLBP, expectNone, 0, '0));
        rows.push_back(moveRow("probe index", `RS_MF, `CP0_INDEX, 0, expectRead, 32'd5));
        rows.push_back(moveRow("hi absent", `RS_MT, `CP0_ENTRYHI, missHi, expectNone, 0));
        rows.push_back(opRow("tlbp miss", `FN_TLBP, expectNone, 0, '0));
        rows.push_back(moveRow("probe miss", `RS_MF, `CP0_INDEX, 0, expectMiss, 0));

        code1 = randomCode();
        pc1   = randomWord();
        bad1  = randomWord();
        rows.push_back(moveRow("irq enable", `RS_MT, `CP0_STATUS, 32'h1000_FF01,
                               expectAllow, 32'd1));
        rows.push_back(excRow("exc over mfc", code1, pc1, 1'b1, bad1, 1'b1,
                              ebaseExp + `EXC_OFFSET));
        rows.push_back(idleRow("exl blocks irq", expectAllow));
        rows.push_back(moveRow("epc", `RS_MF, `CP0_EPC, 0, expectRead, pc1));
        causeExp = {1'b1, causeExp[30:7], code1, causeExp[1:0]};
        rows.push_back(moveRow("cause code", `RS_MF, `CP0_CAUSE, 0, expectRead, causeExp));
        rows.push_back(moveRow("badvaddr", `RS_MF, `CP0_BADVADDR, 0, expectRead, bad1));
        rows.push_back(opRow("eret", `FN_ERET, expectRedirect, pc1, '0));
        rows.push_back(idleRow("eret allows irq", expectAllow));
        rows[rows.size() - 1].expWord = 32'd1;

        code2 = randomCode();
        pc2   = randomWord();
        bad2  = randomWord();
        rows.push_back(excRow("exc no vaddr", code2, pc2, 1'b0, bad2, 1'b0,
                              ebaseExp + `EXC_OFFSET));
        rows.push_back(moveRow("badvaddr kept", `RS_MF, `CP0_BADVADDR, 0, expectRead, bad1));
        rows.push_back(moveRow("epc again", `RS_MF, `CP0_EPC, 0, expectRead, pc2));
        causeExp = {1'b0, causeExp[30:7], code2, causeExp[1:0]};
        rows.push_back(moveRow("cause again", `RS_MF, `CP0_CAUSE, 0, expectRead, causeExp));
        rows.push_back(opRow("eret again", `FN_ERET, expectRedirect, pc2, '0));

        // IM is all ones at this point
        r = moveRow("soft irq", `RS_MT, `CP0_CAUSE, 32'h0000_0300, expectFlags,
                    {24'd0, 8'hFF & {6'h2A, 2'b11}});
        r.hint = 6'h2A;
        rows.push_back(r);
        r = moveRow("irq mask", `RS_MT, `CP0_STATUS, 32'h1000_0F01, expectFlags,
                    {24'd0, 8'h0F & {6'h3F, 2'b11}});
        r.hint = 6'h3F;
        rows.push_back(r);
    endtask

    task automatic applyRow(testRow r);
        instr            <= r.instr;
        instrValid       <= r.valid;
        rtData           <= r.rtData;
        hint             <= r.hint;
        excReq           <= r.excReq;
        excCode          <= r.excCode;
        excPc            <= r.excPc;
        excBd            <= r.excBd;
        excBadVaddr      <= r.badVaddr;
        excBadVaddrValid <= r.badValid;
    endtask

    task automatic checkWord(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkEntry(string name, tlbEntry expected, tlbEntry actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic evaluateRow(testRow r);
        checkBit({r.name, " rtWrite"}, r.kind == expectRead || r.kind == expectMiss, rtWrite);
        checkBit({r.name, " redirect"}, r.kind == expectRedirect, redirect);
        case (r.kind)
            expectRead:     checkWord(r.name, r.expWord, rtResult);
            expectMiss:     checkBit({r.name, " index[31]"}, 1'b1, rtResult[31]);
            expectRedirect: checkWord(r.name, r.expWord, redirectPc);
            expectEntry:    checkEntry(r.name, r.expEntry, i_cop0Top.readEntry);
            expectAllow:    checkBit(r.name, r.expWord[0], allowInterrupt);
            expectFlags:    checkWord(r.name, r.expWord, {24'd0, interruptFlag});
            expectAsid:     checkWord(r.name, r.expWord, {24'd0, asid});
            expectUncached: checkBit(r.name, r.expWord[0], kseg0Uncached);
            default: begin
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: table not finished after %0d cycles", cycles);
            $display("TB FAILED");
            $fatal(1);
        end else if (i_cop0Top.i_cop0Assert.failCount != 0) begin
            $display("Assertion failure seen by cycle %0d", cycles);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        lfsr = 32'h1920a03c;
        applyRow(idleRow("init", expectNone));
        buildTable();
        cycleLimit = 4 * rows.size() + 20;
        @(negedge rst);
        // Row i goes in while row i-1 is checked
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            if (i < rows.size())
                applyRow(rows[i]);
            else
                applyRow(idleRow("drain", expectNone));
            if (i > 0) begin
                @(negedge clk);
                evaluateRow(rows[i - 1]);
            end
        end
        repeat (2) @(negedge clk);
        if (i_cop0Top.i_cop0Assert.failCount != 0) begin
            $display("%0d assertion failures", i_cop0Top.i_cop0Assert.failCount);
            $display("TB FAILED");
            $fatal(1);
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+src
src/cop0Pkg.sv
src/cop0Decode.sv
src/cop0Regs.sv
src/tlbArray.sv
src/trapSequencer.sv
src/cop0Top.sv
tests/clockGen.sv
tests/cop0_assert.sv
tests/cop0Tb.sv
